// File: camera.f
+incdir+source
source/camera_pkg.sv
source/pixel_stream_if.sv
source/debayer.sv
source/metering.sv
source/crop.sv
source/image_buffer.sv
source/camera_command.sv
source/camera.sv
bench/camera_properties.sv
bench/camera_tb.sv

// File: Bender.yml
package:
  name: camera

sources:
  - include_dirs:
      - source
    files:
      - source/camera_pkg.sv
      - source/pixel_stream_if.sv
      - source/debayer.sv
      - source/metering.sv
      - source/crop.sv
      - source/image_buffer.sv
      - source/camera_command.sv
      - source/camera.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/camera_properties.sv
      - bench/camera_tb.sv

// File: bench/camera_tb.sv
// Camera testbench: random Bayer frames and host commands checked against a reference model
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module camera_tb;

    localparam int PIX_W = `SENSOR_WIDTH / 2;
    localparam int PIX_H = `SENSOR_HEIGHT / 2;
    localparam int LINE_CYCLES = `SENSOR_WIDTH + 2;
    localparam int FRAME_CYCLES = 1 + `SENSOR_HEIGHT * LINE_CYCLES + 4;
    localparam int COMMAND_CYCLES = 5;
    localparam int READ_CYCLES = `CAPTURE_BYTES * 4 + 2;
    // Five frames, about twenty single commands, three full reads, doubled
    localparam int CYCLE_LIMIT =
        2 * (5 * FRAME_CYCLES + 20 * COMMAND_CYCLES + 3 * READ_CYCLES + 40);

    logic clock_spi_in;
    logic mipi_byte_reset_n;
    camera_pkg::raw_sample_t pixel_data_i;
    logic line_valid_i;
    logic frame_valid_i;
    camera_pkg::byte_t op_code_i;
    logic op_code_valid_i;
    logic operand_valid_i;
    camera_pkg::byte_t operand_count_i;
    camera_pkg::byte_t response_o;
    logic response_valid_o;

    integer seed = 32'haa0656d2;
    int cycles = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // Reference model state
    camera_pkg::raw_sample_t samples [`SENSOR_HEIGHT][`SENSOR_WIDTH];
    camera_pkg::meter_t expected_average [3];
    camera_pkg::byte_t frame_window [`CAPTURE_BYTES];
    camera_pkg::byte_t captured_window [`CAPTURE_BYTES];

    camera uut (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_data_i     (pixel_data_i),
        .line_valid_i     (line_valid_i),
        .frame_valid_i    (frame_valid_i),
        .op_code_i        (op_code_i),
        .op_code_valid_i  (op_code_valid_i),
        .operand_valid_i  (operand_valid_i),
        .operand_count_i  (operand_count_i),
        .response_o       (response_o),
        .response_valid_o (response_valid_o)
    );

    bind camera_command camera_properties properties (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_valid_i  (op_code_valid_i),
        .response_valid_i (response_valid_o),
        .capture_state_i  (capture_state),
        .read_address_i   (read_address_o)
    );

    initial clock_spi_in = 1'b0;
    always #5 clock_spi_in = ~clock_spi_in;

    always @(posedge clock_spi_in) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_spi_in);
        #1;
    endtask

    task automatic check_response(input camera_pkg::byte_t expected);
        if (response_valid_o !== 1'b1) begin
            $display("** Error at %0t ns: response_valid_o = %b, expected 1",
                     $time, response_valid_o);
            test_errors++;
        end
        if (response_o !== expected) begin
            $display("** Error at %0t ns: response_o = %h, expected %h",
                     $time, response_o, expected);
            test_errors++;
        end
    endtask

    task automatic send_command(input camera_pkg::byte_t op, input camera_pkg::byte_t count,
                                input camera_pkg::byte_t expected);
        op_code_i = op;
        operand_count_i = count;
        op_code_valid_i = 1'b1;
        wait_cycles(3);
        check_response(expected);
        op_code_valid_i = 1'b0;
        wait_cycles(2);
    endtask

    task automatic check_bytes_available(input int remaining);
        send_command(`OP_BYTES_AVAILABLE, 8'd0, camera_pkg::byte_t'(remaining >> 8));
        send_command(`OP_BYTES_AVAILABLE, 8'd1, camera_pkg::byte_t'(remaining & 8'hff));
    endtask

    // One cycle of the capture op-code, only the valid flag is checked
    task automatic arm_capture();
        op_code_i = `OP_CAPTURE;
        operand_count_i = 8'd0;
        op_code_valid_i = 1'b1;
        wait_cycles(1);
        op_code_valid_i = 1'b0;
        if (response_valid_o !== 1'b1) begin
            $display("** Error at %0t ns: response_valid_o = %b, expected 1",
                     $time, response_valid_o);
            test_errors++;
        end
        wait_cycles(1);
    endtask

    task automatic model_frame();
        int sum [3];
        int red;
        int green;
        int blue;
        int index;
        sum = '{0, 0, 0};
        index = 0;
        for (int y = 0; y < PIX_H; y++) begin
            for (int x = 0; x < PIX_W; x++) begin
                // RGGB quad, greens averaged and rounded down
                red = int'(samples[2*y][2*x]);
                green = (int'(samples[2*y][2*x+1]) + int'(samples[2*y+1][2*x])) / 2;
                blue = int'(samples[2*y+1][2*x+1]);
                sum[0] += red >> 2;
                sum[1] += green >> 2;
                sum[2] += blue >> 2;
                if (x >= `CROP_X_START && x < `CROP_X_END
                        && y >= `CROP_Y_START && y < `CROP_Y_END) begin
                    frame_window[index] = {red[9:7], green[9:7], blue[9:8]};
                    index++;
                end
            end
        end
        for (int c = 0; c < 3; c++) begin
            expected_average[c] = camera_pkg::meter_t'(sum[c] >> `METER_SHIFT);
        end
    endtask

    task automatic drive_frame();
        int value;
        frame_valid_i = 1'b1;
        wait_cycles(1);
        for (int row = 0; row < `SENSOR_HEIGHT; row++) begin
            for (int col = 0; col < `SENSOR_WIDTH; col++) begin
                value = $random(seed);
                samples[row][col] = value[9:0];
                pixel_data_i = value[9:0];
                line_valid_i = 1'b1;
                wait_cycles(1);
            end
            line_valid_i = 1'b0;
            wait_cycles(2);
        end
        frame_valid_i = 1'b0;
        wait_cycles(4);
        model_frame();
    endtask

    task automatic read_window();
        op_code_i = `OP_READ_DATA;
        operand_count_i = 8'd0;
        op_code_valid_i = 1'b1;
        for (int i = 0; i < `CAPTURE_BYTES; i++) begin
            wait_cycles(3);
            check_response(captured_window[i]);
            // Rising edge steps to the next byte
            operand_valid_i = 1'b1;
            wait_cycles(1);
            operand_valid_i = 1'b0;
        end
        op_code_valid_i = 1'b0;
        wait_cycles(2);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        mipi_byte_reset_n = 1'b0;
        pixel_data_i = '0;
        line_valid_i = 1'b0;
        frame_valid_i = 1'b0;
        op_code_i = '0;
        op_code_valid_i = 1'b0;
        operand_valid_i = 1'b0;
        operand_count_i = '0;
        repeat (3) @(posedge clock_spi_in);
        #1;
        mipi_byte_reset_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            wait_cycles(1);
            if (response_valid_o !== 1'b0) begin
                $display("** Error at %0t ns: response_valid_o = %b, expected 0",
                         $time, response_valid_o);
                test_errors++;
            end
        end
        for (int c = 0; c < 3; c++) begin
            send_command(`OP_METERING, camera_pkg::byte_t'(c), 8'd0);
        end
        finish_test("reset state and zero metering");

        drive_frame();
        for (int c = 0; c < 3; c++) begin
            send_command(`OP_METERING, camera_pkg::byte_t'(c), expected_average[c]);
        end
        finish_test("metering of one random frame");

        arm_capture();
        drive_frame();
        captured_window = frame_window;
        check_bytes_available(`CAPTURE_BYTES);
        finish_test("capture then bytes available");

        read_window();
        check_bytes_available(0);
        finish_test("read of the captured window");

        arm_capture();
        fork
            drive_frame();
            begin
                // Raw line 7 lies inside the window rows, capture is active
                wait_cycles(1 + 7 * LINE_CYCLES);
                arm_capture();
            end
        join
        captured_window = frame_window;
        drive_frame();
        check_bytes_available(`CAPTURE_BYTES);
        read_window();
        finish_test("capture op-code ignored while active, idle frame not stored");

        arm_capture();
        drive_frame();
        captured_window = frame_window;
        check_bytes_available(`CAPTURE_BYTES);
        read_window();
        finish_test("second capture of a fresh frame");

        if (uut.camera_command.properties.assertion_failures != 0) begin
            $display("Protocol assertions fired %0d times",
                     uut.camera_command.properties.assertion_failures);
            tests_failed++;
        end
        $display("Summary: %0d run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/camera_properties.sv
// Camera command properties: response timing, capture FSM order and read address range
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module camera_properties (
    input wire logic                       clock_spi_in,
    input wire logic                       mipi_byte_reset_n,
    input wire logic                       op_code_valid_i,
    input wire logic                       response_valid_i,
    input wire camera_pkg::capture_state_t capture_state_i,
    input wire camera_pkg::buffer_addr_t   read_address_i
);

    // Read by the testbench at the end of the run
    int assertion_failures = 0;

    response_after_op_code: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        op_code_valid_i |=> response_valid_i
    ) else begin
        assertion_failures++;
        $error("response_valid_o low one cycle after an op-code cycle");
    end

    no_response_without_op_code: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        !op_code_valid_i |=> !response_valid_i
    ) else begin
        assertion_failures++;
        $error("response_valid_o high one cycle after a cycle without op-code");
    end

    // Capture has to pass through armed
    idle_never_to_active: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        capture_state_i == camera_pkg::CAPTURE_IDLE
            |=> capture_state_i != camera_pkg::CAPTURE_ACTIVE
    ) else begin
        assertion_failures++;
        $error("capture FSM went from idle straight to active");
    end

    read_address_in_range: assert property (
        @(posedge clock_spi_in) disable iff (!mipi_byte_reset_n)
        read_address_i <= `CAPTURE_BYTES
    ) else begin
        assertion_failures++;
        $error("read address beyond the captured window");
    end

endmodule

`default_nettype wire

// File: source/camera.sv
// Camera top level: debayer, metering, crop, image buffer and SPI command block
`timescale 1ns/1ps
`default_nettype none

module camera (
    input  wire logic                    clock_spi_in,
    input  wire logic                    mipi_byte_reset_n,
    input  wire camera_pkg::raw_sample_t pixel_data_i,
    input  wire logic                    line_valid_i,
    input  wire logic                    frame_valid_i,
    input  wire camera_pkg::byte_t       op_code_i,
    input  wire logic                    op_code_valid_i,
    input  wire logic                    operand_valid_i,
    input  wire camera_pkg::byte_t       operand_count_i,
    output camera_pkg::byte_t            response_o,
    output logic                         response_valid_o
);

    pixel_stream_if debayered ();
    pixel_stream_if cropped ();

    camera_pkg::meter_t red_metering;
    camera_pkg::meter_t green_metering;
    camera_pkg::meter_t blue_metering;
    logic capture_active;
    camera_pkg::buffer_addr_t read_address;
    camera_pkg::byte_t read_data;

    debayer debayer (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_data_i     (pixel_data_i),
        .line_valid_i     (line_valid_i),
        .frame_valid_i    (frame_valid_i),
        .out_o            (debayered.source)
    );

    metering metering (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .in_i             (debayered.sink),
        .red_metering_o   (red_metering),
        .green_metering_o (green_metering),
        .blue_metering_o  (blue_metering)
    );

    crop crop (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .in_i             (debayered.sink),
        .out_o            (cropped.source)
    );

    image_buffer image_buffer (
        .clock_spi_in     (clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .in_i             (cropped.sink),
        .capture_active_i (capture_active),
        .read_address_i   (read_address),
        .read_data_o      (read_data)
    );

    // Capture follows the edges of the cropped frame flag
    camera_command camera_command (
        .clock_spi_in         (clock_spi_in),
        .mipi_byte_reset_n    (mipi_byte_reset_n),
        .op_code_i            (op_code_i),
        .op_code_valid_i      (op_code_valid_i),
        .operand_valid_i      (operand_valid_i),
        .operand_count_i      (operand_count_i),
        .cropped_frame_valid_i(cropped.frame_valid),
        .red_metering_i       (red_metering),
        .green_metering_i     (green_metering),
        .blue_metering_i      (blue_metering),
        .capture_active_o     (capture_active),
        .read_address_o       (read_address),
        .read_data_i          (read_data),
        .response_o           (response_o),
        .response_valid_o     (response_valid_o)
    );

endmodule

`default_nettype wire

// File: source/camera_command.sv
// Camera command: op-code decoder, capture FSM and response register
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module camera_command (
    input  wire logic                clock_spi_in,
    input  wire logic                mipi_byte_reset_n,
    input  wire camera_pkg::byte_t   op_code_i,
    input  wire logic                op_code_valid_i,
    input  wire logic                operand_valid_i,
    input  wire camera_pkg::byte_t   operand_count_i,
    input  wire logic                cropped_frame_valid_i,
    input  wire camera_pkg::meter_t  red_metering_i,
    input  wire camera_pkg::meter_t  green_metering_i,
    input  wire camera_pkg::meter_t  blue_metering_i,
    output logic                     capture_active_o,
    output camera_pkg::buffer_addr_t read_address_o,
    input  wire camera_pkg::byte_t   read_data_i,
    output camera_pkg::byte_t        response_o,
    output logic                     response_valid_o
);

    camera_pkg::capture_state_t capture_state;
    camera_pkg::buffer_addr_t bytes_read;
    camera_pkg::buffer_addr_t bytes_remaining;
    logic frame_valid_q;
    logic frame_rise;
    logic frame_fall;
    logic operand_valid_q;
    logic arm;
    logic read_step;

    assign frame_rise = cropped_frame_valid_i && !frame_valid_q;
    assign frame_fall = !cropped_frame_valid_i && frame_valid_q;
    assign arm = op_code_valid_i && (op_code_i == `OP_CAPTURE)
              && (capture_state == camera_pkg::CAPTURE_IDLE);
    // One byte per rising edge of operand valid
    assign read_step = op_code_valid_i && (op_code_i == `OP_READ_DATA)
                    && operand_valid_i && !operand_valid_q;
    assign bytes_remaining = camera_pkg::buffer_addr_t'(`CAPTURE_BYTES) - bytes_read;
    assign read_address_o = bytes_read;

    // Active already in the edge cycle, which carries the first pixel
    assign capture_active_o = (capture_state == camera_pkg::CAPTURE_ACTIVE)
                           || (capture_state == camera_pkg::CAPTURE_ARMED && frame_rise);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            capture_state <= camera_pkg::CAPTURE_IDLE;
            frame_valid_q <= 1'b0;
            operand_valid_q <= 1'b0;
            bytes_read <= '0;
        end else begin
            frame_valid_q <= cropped_frame_valid_i;
            operand_valid_q <= operand_valid_i;
            case (capture_state)
                camera_pkg::CAPTURE_IDLE: begin
                    if (arm) begin
                        capture_state <= camera_pkg::CAPTURE_ARMED;
                    end
                end
                camera_pkg::CAPTURE_ARMED: begin
                    if (frame_rise) begin
                        capture_state <= camera_pkg::CAPTURE_ACTIVE;
                    end
                end
                camera_pkg::CAPTURE_ACTIVE: begin
                    if (frame_fall) begin
                        capture_state <= camera_pkg::CAPTURE_IDLE;
                    end
                end
                default: capture_state <= camera_pkg::CAPTURE_IDLE;
            endcase
            if (arm) begin
                bytes_read <= '0;
            end else if (read_step && bytes_read < `CAPTURE_BYTES) begin
                bytes_read <= bytes_read + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            response_o <= '0;
            response_valid_o <= 1'b0;
        end else begin
            response_valid_o <= op_code_valid_i;
            if (op_code_valid_i) begin
                case (op_code_i)
                    `OP_BYTES_AVAILABLE: begin
                        // High byte first
                        if (operand_count_i == 8'd0) begin
                            response_o <= bytes_remaining[15:8];
                        end else begin
                            response_o <= bytes_remaining[7:0];
                        end
                    end
                    `OP_READ_DATA: response_o <= read_data_i;
                    `OP_METERING: begin
                        case (operand_count_i)
                            8'd0: response_o <= red_metering_i;
                            8'd1: response_o <= green_metering_i;
                            default: response_o <= blue_metering_i;
                        endcase
                    end
                    default: response_o <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/image_buffer.sv
// Image buffer: stores one cropped frame as RGB332 bytes with registered reads
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module image_buffer (
    input  wire logic                     clock_spi_in,
    input  wire logic                     mipi_byte_reset_n,
    pixel_stream_if.sink                  in_i,
    input  wire logic                     capture_active_i,
    input  wire camera_pkg::buffer_addr_t read_address_i,
    output camera_pkg::byte_t             read_data_o
);

    localparam int SAMPLE_W = $bits(camera_pkg::raw_sample_t);
    localparam int DEPTH = `CAPTURE_BYTES;
    localparam int ADDR_W = $clog2(DEPTH);

    camera_pkg::byte_t memory [DEPTH];
    camera_pkg::buffer_addr_t write_address;
    camera_pkg::byte_t packed_pixel;
    logic write_enable;

    // RGB332 from the top bits of each channel
    assign packed_pixel = {in_i.red[SAMPLE_W-1 -: 3],
                           in_i.green[SAMPLE_W-1 -: 3],
                           in_i.blue[SAMPLE_W-1 -: 2]};

    assign write_enable = in_i.pixel_valid && capture_active_i && (write_address < DEPTH);

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            write_address <= '0;
        end else if (!in_i.frame_valid) begin
            write_address <= '0;
        end else if (in_i.pixel_valid) begin
            write_address <= write_address + 1'b1;
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (write_enable) begin
            memory[write_address[ADDR_W-1:0]] <= packed_pixel;
        end
        read_data_o <= memory[read_address_i[ADDR_W-1:0]];
    end

endmodule

`default_nettype wire

// File: source/crop.sv
// Crop: keeps the pixels of a fixed window and frames them with their own flag
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module crop (
    input  wire logic      clock_spi_in,
    input  wire logic      mipi_byte_reset_n,
    pixel_stream_if.sink   in_i,
    pixel_stream_if.source out_o
);

    localparam int PIX_W = `SENSOR_WIDTH / 2;
    localparam int X_W = $clog2(PIX_W);
    localparam int Y_W = $clog2(`SENSOR_HEIGHT / 2);

    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic in_window;
    logic window_pixel;
    logic last_q;

    assign in_window = (x >= `CROP_X_START) && (x < `CROP_X_END)
                    && (y >= `CROP_Y_START) && (y < `CROP_Y_END);
    assign window_pixel = in_i.pixel_valid && in_window;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x <= '0;
            y <= '0;
            last_q <= 1'b0;
            out_o.pixel_valid <= 1'b0;
            out_o.frame_valid <= 1'b0;
        end else begin
            if (!in_i.frame_valid) begin
                x <= '0;
                y <= '0;
            end else if (in_i.pixel_valid) begin
                if (x == PIX_W - 1) begin
                    x <= '0;
                    y <= y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
            last_q <= window_pixel && (x == `CROP_X_END - 1) && (y == `CROP_Y_END - 1);
            out_o.pixel_valid <= window_pixel;
            // Window frame opens on its first pixel, closes after its last
            if (!in_i.frame_valid || last_q) begin
                out_o.frame_valid <= 1'b0;
            end else if (window_pixel) begin
                out_o.frame_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (window_pixel) begin
            out_o.red <= in_i.red;
            out_o.green <= in_i.green;
            out_o.blue <= in_i.blue;
        end
    end

endmodule

`default_nettype wire

// File: source/metering.sv
// Metering: averages the top 8 bits of each colour over a debayered frame
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module metering (
    input  wire logic          clock_spi_in,
    input  wire logic          mipi_byte_reset_n,
    pixel_stream_if.sink       in_i,
    output camera_pkg::meter_t red_metering_o,
    output camera_pkg::meter_t green_metering_o,
    output camera_pkg::meter_t blue_metering_o
);

    localparam int SAMPLE_W = $bits(camera_pkg::raw_sample_t);
    localparam int METER_W = $bits(camera_pkg::meter_t);
    localparam int ACC_W = METER_W + `METER_SHIFT;

    // Channel order is red, green, blue
    camera_pkg::raw_sample_t channel [3];
    logic [ACC_W-1:0] accumulator [3];
    camera_pkg::meter_t average [3];
    logic frame_valid_q;
    logic frame_end;

    assign channel[0] = in_i.red;
    assign channel[1] = in_i.green;
    assign channel[2] = in_i.blue;
    assign frame_end = frame_valid_q && !in_i.frame_valid;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                accumulator[i] <= '0;
                average[i] <= '0;
            end
        end else begin
            frame_valid_q <= in_i.frame_valid;
            for (int i = 0; i < 3; i++) begin
                if (frame_end) begin
                    // Divide by the pixel count and start over
                    average[i] <= accumulator[i][ACC_W-1:`METER_SHIFT];
                    accumulator[i] <= '0;
                end else if (in_i.pixel_valid) begin
                    accumulator[i] <= accumulator[i]
                        + {{`METER_SHIFT{1'b0}}, channel[i][SAMPLE_W-1 -: METER_W]};
                end
            end
        end
    end

    assign red_metering_o = average[0];
    assign green_metering_o = average[1];
    assign blue_metering_o = average[2];

endmodule

`default_nettype wire

// File: source/debayer.sv
// Debayer: reduces each 2x2 RGGB quad of the raw stream to one RGB pixel
`timescale 1ns/1ps
`include "camera_config.svh"
`default_nettype none

module debayer (
    input  wire logic                    clock_spi_in,
    input  wire logic                    mipi_byte_reset_n,
    input  wire camera_pkg::raw_sample_t pixel_data_i,
    input  wire logic                    line_valid_i,
    input  wire logic                    frame_valid_i,
    pixel_stream_if.source               out_o
);

    localparam int SAMPLE_W = $bits(camera_pkg::raw_sample_t);
    localparam int COL_W = $clog2(`SENSOR_WIDTH);
    localparam int LINE_W = $clog2(`SENSOR_HEIGHT);
    localparam int QUADS = `SENSOR_WIDTH / 2;

    logic [COL_W-1:0] column;
    logic [LINE_W-1:0] line;
    logic line_valid_q;
    logic [COL_W-2:0] quad;
    logic quad_done;

    // Half-line buffer holds the top row of every quad
    camera_pkg::raw_sample_t red_line [QUADS];
    camera_pkg::raw_sample_t green_line [QUADS];
    camera_pkg::raw_sample_t green_odd;
    logic [SAMPLE_W:0] green_sum;

    assign quad = column[COL_W-1:1];
    // Blue sample closes the quad
    assign quad_done = line_valid_i && line[0] && column[0];
    assign green_sum = {1'b0, green_line[quad]} + {1'b0, green_odd};

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            column <= '0;
            line <= '0;
            line_valid_q <= 1'b0;
            out_o.pixel_valid <= 1'b0;
            out_o.frame_valid <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            if (line_valid_i) begin
                column <= column + 1'b1;
            end else begin
                column <= '0;
            end
            // Next line on the falling edge of line valid
            if (!frame_valid_i) begin
                line <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                line <= line + 1'b1;
            end
            out_o.pixel_valid <= quad_done;
            out_o.frame_valid <= frame_valid_i;
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (line_valid_i && !line[0]) begin
            if (!column[0]) begin
                red_line[quad] <= pixel_data_i;
            end else begin
                green_line[quad] <= pixel_data_i;
            end
        end
        if (line_valid_i && line[0] && !column[0]) begin
            green_odd <= pixel_data_i;
        end
        if (quad_done) begin
            out_o.red <= red_line[quad];
            out_o.green <= green_sum[SAMPLE_W:1];
            out_o.blue <= pixel_data_i;
        end
    end

endmodule

`default_nettype wire

// File: source/pixel_stream_if.sv
// Pixel stream interface: one debayered RGB pixel per valid cycle plus frame flag
`timescale 1ns/1ps
`default_nettype none

interface pixel_stream_if;

    camera_pkg::raw_sample_t red;
    camera_pkg::raw_sample_t green;
    camera_pkg::raw_sample_t blue;
    logic pixel_valid;
    // High over the whole frame
    logic frame_valid;

    modport source (
        output red, green, blue, pixel_valid, frame_valid
    );

    modport sink (
        input red, green, blue, pixel_valid, frame_valid
    );

endinterface

`default_nettype wire

// File: source/camera_pkg.sv
// Camera package: sample, channel, byte, address and capture state types
`default_nettype none

package camera_pkg;

    // Sensor sample and debayered colour channel
    typedef logic [9:0] raw_sample_t;

    // One channel's frame average
    typedef logic [7:0] meter_t;

    // Command, response or RGB332 byte
    typedef logic [7:0] byte_t;

    // Image buffer address and byte counts
    typedef logic [15:0] buffer_addr_t;

    typedef enum logic [1:0] {
        CAPTURE_IDLE,
        CAPTURE_ARMED,
        CAPTURE_ACTIVE
    } capture_state_t;

endpackage

`default_nettype wire

// File: source/camera_config.svh
// Camera configuration: sensor size, crop window and command op-codes
`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// Raw sensor frame in samples; debayered frame is half of each
`define SENSOR_WIDTH  16
`define SENSOR_HEIGHT 16

// log2 of the debayered pixel count per frame
`define METER_SHIFT 6

// Crop window in debayered pixels, start inclusive, end exclusive
`define CROP_X_START 2
`define CROP_X_END   6
`define CROP_Y_START 2
`define CROP_Y_END   6

// One RGB332 byte per cropped pixel
`define CAPTURE_BYTES 16

`define OP_CAPTURE         8'h20
`define OP_BYTES_AVAILABLE 8'h21
`define OP_READ_DATA       8'h22
`define OP_METERING        8'h25

`endif
